//--- femtoQuark.f
verilog/quarkPkg.sv
verilog/decodeBus.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/shiftAlu.sv
verilog/loadStoreUnit.sv
verilog/quarkControl.sv
verilog/femtoQuark.sv
testbench/quarkMemory.sv
testbench/femtoQuarkTb.sv

//--- runSim.sh
#!/bin/bash
# Build and run the femtoQuark testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f femtoQuark.f --top-module femtoQuarkTb \
   -o femtoQuarkSim --Mdir obj_dir > build.log 2>&1 &&
{ ./obj_dir/femtoQuarkSim > sim.log 2>&1 || true; } &&
cat sim.log || { echo "Build failed, see build.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } ||
grep -q "No errors" sim.log && echo "Simulation passed" ||
{ echo "Simulation ended without a verdict"; exit 1; }

//--- testbench/femtoQuarkTb.sv
`timescale 1ns/1ps
`default_nettype none

module femtoQuarkTb;
   localparam logic [6:0] opcLoad = 7'b0000011, opcImm = 7'b0010011, opcAuipc = 7'b0010111;
   localparam logic [6:0] opcStore = 7'b0100011, opcReg = 7'b0110011, opcLui = 7'b0110111;
   localparam logic [6:0] opcBranch = 7'b1100011, opcJalr = 7'b1100111, opcJal = 7'b1101111;
   localparam int     resultIndex  = 1024;   // Word index of x31 = 0x1000
   localparam int     markerAddr   = 32'h17fc;
   localparam int     maxProgWords = 256;
   localparam longint watchdogNs   = 64'd5 * maxProgWords * 48 * 100;  // Runs x words x worst cycles

   logic clk, reset, stretch, memRstrb, memRbusy, memWbusy;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic [31:0] prog[$], expected[$];
   integer seed = 32'hb037;
   integer aluSeed;

   femtoQuark u_femtoQuark (.clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
                            .memRstrb, .memRbusy, .memWbusy);
   quarkMemory u_quarkMemory (.clk, .reset, .stretch, .addr(memAddr), .wdata(memWdata),
      .wmask(memWmask), .rdata(memRdata), .rstrb(memRstrb), .rbusy(memRbusy), .wbusy(memWbusy));

   always #50 clk = ~clk;

   initial begin
      #(watchdogNs);
      $display("Errors found");
      $fatal(1, "Timeout, the program never stored to the end marker");
   end

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Errors found");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // ****************************************
   // Instruction encoders
   // ****************************************
   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction
   function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, rs1,
                                        input logic [2:0] f3, input int rd);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opcReg};
   endfunction
   function automatic logic [31:0] encI(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd, input logic [6:0] op);
      return {imm, 5'(rs1), f3, 5'(rd), op};
   endfunction
   function automatic logic [31:0] encS(input logic [11:0] imm, input int rs2, rs1,
                                        input logic [2:0] f3);
      return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], opcStore};
   endfunction
   function automatic logic [31:0] encB(input logic [12:0] imm, input int rs2, rs1,
                                        input logic [2:0] f3);
      return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opcBranch};
   endfunction
   function automatic logic [31:0] encJ(input logic [20:0] imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), opcJal};
   endfunction

   function automatic int pcNow();
      return prog.size() * 4;
   endfunction

   task automatic loadConst(input int rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = v - sext12(v[11:0]);                  // Undo the sign of the addi part
      prog.push_back({upper[31:12], 5'(rd), opcLui});
      prog.push_back(encI(v[11:0], rd, 3'd0, rd, opcImm));
   endtask

   task automatic saveResult(input int rs, input logic [31:0] exp);
      prog.push_back(encS(12'(expected.size() * 4), rs, 31, 3'd2));
      expected.push_back(exp);
   endtask

   task automatic startProgram();
      prog.delete();
      expected.delete();
      prog.push_back({20'd1, 5'd31, opcLui});       // x31 = result area
   endtask

   // ****************************************
   // Run a program and compare its results
   // ****************************************
   task automatic runProgram(input string name, input logic stretchOn);
      prog.push_back(encS(12'h7fc, 0, 31, 3'd2));   // End marker
      prog.push_back(encJ(21'd0, 0));               // Park in a loop
      if (prog.size() > maxProgWords) begin
         $display("Errors found");
         $fatal(1, "Program %s is longer than the watchdog allows", name);
      end
      for (int i = 0; i < 2048; i++) u_quarkMemory.words[i] = i * 32'h9e3779b9 ^ 32'h5a5a0000;
      foreach (prog[i]) u_quarkMemory.words[i] = prog[i];
      @(posedge clk);
      reset   <= 1'b0;
      stretch <= stretchOn;
      repeat (2) begin
         @(posedge clk);                            // Reset sampled low
         @(negedge clk);
         check(memWmask, 0, {name, " write mask during reset"});
         check(memRstrb, 0, {name, " read strobe during reset"});
      end
      @(posedge clk);                               // Third edge with reset low
      reset <= 1'b1;
      @(negedge clk);
      check(memWmask, 0, {name, " write mask right after reset"});
      check(memRstrb, 0, {name, " read strobe right after reset"});
      while (!memRstrb) @(negedge clk);
      check(memAddr, 0, {name, " first fetch address"});
      while (!(memWmask != 0 && memAddr == markerAddr)) @(negedge clk);
      @(negedge clk);                               // Marker write has landed
      foreach (expected[k]) begin
         check(u_quarkMemory.words[resultIndex + k], expected[k],
               $sformatf("%s result %0d", name, k));
      end
   endtask

   // ****************************************
   // Directed tests
   // ****************************************
   task automatic aluTest(input logic stretchOn);
      logic [2:0]  opF3 [0:6];
      logic [31:0] a, b, e;
      logic [11:0] imm;
      logic [19:0] upper;
      opF3 = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};  // Index 1 is SUB
      if (!stretchOn) aluSeed = seed;
      else seed = aluSeed;                          // Same operands as the first run
      startProgram();
      for (int rep = 0; rep < 4; rep++) begin
         a = $random(seed);
         b = $random(seed);
         imm = $random(seed);
         loadConst(1, a);
         loadConst(2, b);
         for (int i = 0; i < 7; i++) begin
            prog.push_back(encR(i == 1 ? 7'h20 : 7'h00, 2, 1, opF3[i], 3));
            case (opF3[i])
               3'd0: e = (i == 1) ? a - b : a + b;
               3'd2: e = {31'd0, $signed(a) < $signed(b)};
               3'd3: e = {31'd0, a < b};
               3'd4: e = a ^ b;
               3'd6: e = a | b;
               default: e = a & b;
            endcase
            saveResult(3, e);
            if (i == 1) continue;
            prog.push_back(encI(imm, 1, opF3[i], 4, opcImm));  // Same op with immediate
            b = sext12(imm);
            case (opF3[i])
               3'd0: e = a + b;
               3'd2: e = {31'd0, $signed(a) < $signed(b)};
               3'd3: e = {31'd0, a < b};
               3'd4: e = a ^ b;
               3'd6: e = a | b;
               default: e = a & b;
            endcase
            saveResult(4, e);
            b = $random(seed);
            loadConst(2, b);
         end
         upper = $random(seed);
         prog.push_back({upper, 5'd6, opcLui});
         saveResult(6, {upper, 12'd0});
         e = (pcNow() + {upper, 12'd0}) & 32'h00ffffff;  // PC path is 24 bits wide
         prog.push_back({upper, 5'd7, opcAuipc});
         saveResult(7, e);
      end
      runProgram(stretchOn ? "ALU with busy" : "ALU", stretchOn);
   endtask

   task automatic shiftTest();
      logic [31:0] a, b;
      logic [4:0]  sh;
      startProgram();
      for (int rep = 0; rep < 4; rep++) begin
         a = $random(seed);
         if (rep == 0) a[31] = 1'b1;                 // Force sign fill
         b = $random(seed);
         sh = $random(seed);
         loadConst(1, a);
         loadConst(2, b);
         prog.push_back(encR(7'h00, 2, 1, 3'd1, 3));
         saveResult(3, a << b[4:0]);
         prog.push_back(encR(7'h00, 2, 1, 3'd5, 3));
         saveResult(3, a >> b[4:0]);
         prog.push_back(encR(7'h20, 2, 1, 3'd5, 3));
         saveResult(3, $signed(a) >>> b[4:0]);
         prog.push_back(encI({7'h00, sh}, 1, 3'd1, 3, opcImm));
         saveResult(3, a << sh);
         prog.push_back(encI({7'h00, sh}, 1, 3'd5, 3, opcImm));
         saveResult(3, a >> sh);
         prog.push_back(encI({7'h20, sh}, 1, 3'd5, 3, opcImm));
         saveResult(3, $signed(a) >>> sh);
      end
      runProgram("shift", 1'b0);
   endtask

   task automatic branchTest();
      logic [31:0] a, b;
      logic [2:0]  conds [0:5];
      logic        taken;
      int          p;
      conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      startProgram();
      for (int pair = 0; pair < 3; pair++) begin
         a = (pair == 1) ? 32'hfffffffb : $random(seed);
         b = (pair == 0) ? a : (pair == 1) ? 32'd3 : $random(seed);
         loadConst(1, a);
         loadConst(2, b);
         foreach (conds[i]) begin
            case (conds[i])
               3'd0: taken = (a == b);
               3'd1: taken = (a != b);
               3'd4: taken = ($signed(a) < $signed(b));
               3'd5: taken = ($signed(a) >= $signed(b));
               3'd6: taken = (a < b);
               default: taken = (a >= b);
            endcase
            prog.push_back(encI(12'd0, 0, 3'd0, 5, opcImm));
            prog.push_back(encB(13'd8, 2, 1, conds[i]));
            prog.push_back(encI(12'd1, 5, 3'd0, 5, opcImm));  // Runs only when not taken
            saveResult(5, taken ? 32'd0 : 32'd1);
         end
      end
      prog.push_back(encI(12'd0, 0, 3'd0, 7, opcImm));
      p = pcNow();
      prog.push_back(encJ(21'd8, 6));
      prog.push_back(encI(12'd1, 7, 3'd0, 7, opcImm));         // Skipped by JAL
      saveResult(6, p + 4);
      saveResult(7, 0);
      p = pcNow() + 4;
      prog.push_back(encI(12'(p + 4), 0, 3'd0, 8, opcImm));    // Target minus offset 4
      prog.push_back(encI(12'd4, 8, 3'd0, 9, opcJalr));
      prog.push_back(encI(12'd1, 7, 3'd0, 7, opcImm));         // Skipped by JALR
      saveResult(9, p + 4);
      saveResult(7, 0);
      runProgram("branch", 1'b0);
   endtask

   task automatic loadStoreTest();
      logic [31:0] w, v, d, e;
      startProgram();
      w = $random(seed);
      v = $random(seed);
      loadConst(1, w);
      loadConst(2, v);
      for (int lane = 0; lane < 4; lane++) begin
         e = w;
         e[8*lane +: 8] = v[7:0];
         prog.push_back(encS(12'(expected.size() * 4), 1, 31, 3'd2));
         prog.push_back(encS(12'(expected.size() * 4 + lane), 2, 31, 3'd0));  // SB
         expected.push_back(e);
      end
      for (int lane = 0; lane < 4; lane += 2) begin
         e = w;
         e[8*lane +: 16] = v[15:0];
         prog.push_back(encS(12'(expected.size() * 4), 1, 31, 3'd2));
         prog.push_back(encS(12'(expected.size() * 4 + lane), 2, 31, 3'd1));  // SH
         expected.push_back(e);
      end
      d = $random(seed);
      d[7] = 1'b1;                                   // Mixed signs per lane
      d[15] = 1'b0;
      d[23] = 1'b1;
      d[31] = 1'b1;
      loadConst(1, d);
      prog.push_back(encS(12'h700, 1, 31, 3'd2));
      for (int lane = 0; lane < 4; lane++) begin
         prog.push_back(encI(12'(12'h700 + lane), 31, 3'd0, 3, opcLoad));
         saveResult(3, {{24{d[8*lane+7]}}, d[8*lane +: 8]});
         prog.push_back(encI(12'(12'h700 + lane), 31, 3'd4, 3, opcLoad));
         saveResult(3, {24'd0, d[8*lane +: 8]});
      end
      for (int lane = 0; lane < 4; lane += 2) begin
         prog.push_back(encI(12'(12'h700 + lane), 31, 3'd1, 3, opcLoad));
         saveResult(3, {{16{d[8*lane+15]}}, d[8*lane +: 16]});
         prog.push_back(encI(12'(12'h700 + lane), 31, 3'd5, 3, opcLoad));
         saveResult(3, {16'd0, d[8*lane +: 16]});
      end
      prog.push_back(encI(12'h700, 31, 3'd2, 3, opcLoad));
      saveResult(3, d);
      runProgram("load store", 1'b0);
   endtask

   // ****************************************
   // Test sequence
   // ****************************************
   initial begin
      clk     = 1'b0;
      reset   = 1'b0;
      stretch = 1'b0;
      aluTest(1'b0);
      shiftTest();
      branchTest();
      loadStoreTest();
      aluTest(1'b1);
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/quarkMemory.sv
`timescale 1ns/1ps
`default_nettype none

module quarkMemory (
   input  wire         clk,
   input  wire         reset,     // Active low, clears busy state
   input  wire         stretch,   // Random busy cycles when high
   input  wire  [31:0] addr,
   input  wire  [31:0] wdata,
   input  wire  [3:0]  wmask,
   output logic [31:0] rdata,
   input  wire         rstrb,
   output logic        rbusy,
   output logic        wbusy
);
   logic [31:0] words [0:2047];  // 8 KB, word addressed
   logic [10:0] readIndex;       // Held for a delayed read
   int          readCount;
   int          writeCount;
   int          delay;
   integer      busySeed = 32'hb037;

   initial begin
      rdata = '0;
      rbusy = 1'b0;
      wbusy = 1'b0;
   end

   // ****************************************
   // Read and write ports
   // ****************************************
   always @(posedge clk) begin
      if (!reset) begin
         rbusy      <= 1'b0;
         wbusy      <= 1'b0;
         readCount  <= 0;
         writeCount <= 0;
      end else begin
         if (rstrb) begin
            delay = stretch ? $unsigned($random(busySeed)) % 4 : 0;  // 0..3 extra cycles
            readIndex <= addr[12:2];
            if (delay == 0) begin
               rdata <= words[addr[12:2]];
            end
            rbusy     <= (delay != 0);
            readCount <= delay;
         end else if (readCount != 0) begin
            readCount <= readCount - 1;
            if (readCount == 1) begin
               rdata <= words[readIndex];
               rbusy <= 1'b0;
            end
         end
         if (wmask != 4'b0000) begin
            for (int lane = 0; lane < 4; lane++) begin
               if (wmask[lane]) words[addr[12:2]][8*lane +: 8] <= wdata[8*lane +: 8];
            end
            delay = stretch ? $unsigned($random(busySeed)) % 4 : 0;
            wbusy      <= (delay != 0);
            writeCount <= delay;
         end else if (writeCount != 0) begin
            writeCount <= writeCount - 1;
            if (writeCount == 1) wbusy <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/femtoQuark.sv
`timescale 1ns/1ps
`default_nettype none

module femtoQuark (
   input  wire                      clk,
   input  wire                      reset,      // Active low
   output wire [quarkPkg::xlen-1:0] memAddr,
   output wire [quarkPkg::xlen-1:0] memWdata,
   output wire [3:0]                memWmask,   // One bit per byte lane
   input  wire [quarkPkg::xlen-1:0] memRdata,   // Instructions and load data
   output wire                      memRstrb,   // Read request
   input  wire                      memRbusy,
   input  wire                      memWbusy
);
   import quarkPkg::*;

   logic            instrLoad;
   logic            aluWr;
   logic            writeBack;
   logic [xlen-1:0] writeBackData;
   logic [xlen-1:0] rs1Data;
   logic [xlen-1:0] rs2Data;
   logic [xlen-1:0] aluOut;
   logic [xlen-1:0] aluPlus;
   logic            aluBusy;
   logic            predicate;
   logic [xlen-1:0] loadData;
   logic [3:0]      storeMask;

   decodeBus dec ();  // Decoded instruction shared by all units

   instrDecoder u_instrDecoder (.clk, .memRdata, .instrLoad, .dec(dec.producer));

   registerFile u_registerFile (
      .clk, .rs1(dec.instr.r.rs1), .rs2(dec.instr.r.rs2), .rd(dec.instr.r.rd),
      .writeBack, .writeBackData, .rs1Data, .rs2Data);

   shiftAlu u_shiftAlu (
      .clk, .dec(dec.consumer), .rs1Data, .rs2Data, .aluWr,
      .aluOut, .aluPlus, .aluBusy, .predicate);

   loadStoreUnit u_loadStoreUnit (
      .dec(dec.consumer), .addrLow(memAddr[1:0]), .rs2Data, .memRdata,
      .loadData, .memWdata, .storeMask);

   quarkControl u_quarkControl (
      .clk, .reset, .dec(dec.consumer), .aluOut, .aluPlus, .aluBusy, .predicate,
      .loadData, .storeMask, .memRbusy, .memWbusy, .instrLoad, .aluWr, .writeBack,
      .writeBackData, .memAddr, .memRstrb, .memWmask);

endmodule

`default_nettype wire

//--- verilog/quarkControl.sv
`timescale 1ns/1ps
`default_nettype none

module quarkControl (
   input  wire                       clk,
   input  wire                       reset,          // Active low
   decodeBus.consumer                dec,
   input  wire  [quarkPkg::xlen-1:0] aluOut,
   input  wire  [quarkPkg::xlen-1:0] aluPlus,
   input  wire                       aluBusy,
   input  wire                       predicate,
   input  wire  [quarkPkg::xlen-1:0] loadData,
   input  wire  [3:0]                storeMask,
   input  wire                       memRbusy,
   input  wire                       memWbusy,
   output logic                      instrLoad,      // Latch fetched word
   output logic                      aluWr,
   output logic                      writeBack,
   output logic [quarkPkg::xlen-1:0] writeBackData,
   output logic [quarkPkg::xlen-1:0] memAddr,
   output logic                      memRstrb,
   output logic [3:0]                memWmask
);
   import quarkPkg::*;

   logic [numStates-1:0] state;      // One-hot
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] addrReg;    // Drives memAddr
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;  // Branch, JAL and AUIPC target
   logic                 isAlu;
   logic                 jumpToImm;

   assign isAlu     = dec.isAluImm | dec.isAluReg;
   assign jumpToImm = dec.isJal | (dec.isBranch & predicate);
   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + (dec.isJal   ? dec.immJ[addrWidth-1:0] :
                            dec.isAuipc ? dec.immU[addrWidth-1:0] : dec.immB[addrWidth-1:0]);

   assign memAddr = {{(xlen-addrWidth){1'b0}}, addrReg};

   // ****************************************
   // Strobes decoded from state
   // ****************************************
   assign instrLoad = state[stWaitInstr] & !memRbusy;
   assign aluWr     = state[stExecute] & isAlu;
   assign memRstrb  = state[stFetchInstr] | state[stLoad];
   assign memWmask  = {4{state[stStore]}} & storeMask;
   assign writeBack = !(dec.isBranch | dec.isStore) &
                      (state[stExecute] | state[stWaitAluOrMem]);  // Last write in wait wins

   // Only one source is selected at a time
   assign writeBackData =
      (dec.isLui                ? dec.immU                                : '0) |
      (isAlu                    ? aluOut                                  : '0) |
      (dec.isAuipc              ? {{(xlen-addrWidth){1'b0}}, pcPlusImm}   : '0) |
      ((dec.isJal | dec.isJalr) ? {{(xlen-addrWidth){1'b0}}, pcPlus4}     : '0) |
      (dec.isLoad               ? loadData                                : '0);

   // ****************************************
   // FSM, PC and address register
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state                 <= '0;
         state[stWaitAluOrMem] <= 1'b1;     // Leaves as soon as nothing is busy
         pc                    <= resetAddr;
         addrReg               <= resetAddr;
      end else begin
         case (1'b1)
            state[stExecute]: begin
               pc      <= dec.isJalr ? aluPlus[addrWidth-1:0] :
                          jumpToImm  ? pcPlusImm : pcPlus4;
               // Data address for memory ops, else next fetch address
               addrReg <= (dec.isJalr | dec.isLoad | dec.isStore) ? aluPlus[addrWidth-1:0] :
                          jumpToImm ? pcPlusImm : pcPlus4;
               state                 <= '0;
               state[stStore]        <= dec.isStore;
               state[stLoad]         <= dec.isLoad;
               state[stWaitAluOrMem] <= isAlu;
               state[stFetchInstr]   <= !(dec.isStore | dec.isLoad | isAlu);  // Jumps, LUI, AUIPC
            end
            state[stWaitInstr]: begin
               if (!memRbusy) begin
                  state              <= '0;
                  state[stFetchRegs] <= 1'b1;
               end
            end
            state[stWaitAluOrMem]: begin
               if (!aluBusy & !memRbusy & !memWbusy) begin
                  addrReg             <= pc;        // Back to instruction fetch
                  state               <= '0;
                  state[stFetchInstr] <= 1'b1;
               end
            end
            default: begin
               // Unconditional steps
               state                 <= '0;
               state[stWaitInstr]    <= state[stFetchInstr];
               state[stExecute]      <= state[stFetchRegs];
               state[stWaitAluOrMem] <= state[stLoad] | state[stStore];
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
   decodeBus.consumer                dec,
   input  wire  [1:0]                addrLow,    // Byte offset in the word
   input  wire  [quarkPkg::xlen-1:0] rs2Data,    // Store source
   input  wire  [quarkPkg::xlen-1:0] memRdata,
   output logic [quarkPkg::xlen-1:0] loadData,   // Aligned and extended
   output logic [quarkPkg::xlen-1:0] memWdata,   // Store data on all lanes
   output logic [3:0]                storeMask   // Lanes before state gating
);
   import quarkPkg::*;

   logic        isByte;
   logic        isHalf;
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   // funct3[1:0]: 00 byte, 01 halfword, 10 word
   assign isByte = (dec.instr.r.funct3[1:0] == 2'b00);
   assign isHalf = (dec.instr.r.funct3[1:0] == 2'b01);

   // ****************************************
   // Load alignment
   // ****************************************
   assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.instr.r.funct3[2] &            // LBU and LHU zero extend
                     (isByte ? loadByte[7] : loadHalf[15]);

   assign loadData = isByte ? {{24{loadSign}}, loadByte} :
                     isHalf ? {{16{loadSign}}, loadHalf} : memRdata;

   // ****************************************
   // Store lanes
   // ****************************************
   // Low byte lands on every lane, low half on both halves
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = addrLow[0] ? rs2Data[7:0] :
                            addrLow[1] ? rs2Data[15:8] : rs2Data[31:24];

   always_comb begin
      if (isByte) begin
         storeMask = 4'b0001 << addrLow;                 // One lane
      end else if (isHalf) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;     // Upper or lower half
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

//--- verilog/shiftAlu.sv
`timescale 1ns/1ps
`default_nettype none

module shiftAlu (
   input  wire                       clk,
   decodeBus.consumer                dec,
   input  wire  [quarkPkg::xlen-1:0] rs1Data,
   input  wire  [quarkPkg::xlen-1:0] rs2Data,
   input  wire                       aluWr,      // Start of an ALU operation
   output logic [quarkPkg::xlen-1:0] aluOut,     // Valid once aluBusy is low
   output logic [quarkPkg::xlen-1:0] aluPlus,    // Also used for addresses
   output logic                      aluBusy,
   output logic                      predicate   // Branch condition
);
   import quarkPkg::*;

   logic [xlen-1:0] aluIn1;
   logic [xlen-1:0] aluIn2;
   logic [xlen:0]   aluMinus;  // Extra bit is the borrow
   logic            isEq;
   logic            isLt;
   logic            isLtu;
   logic [xlen-1:0] aluReg;    // Result and shift register
   logic [4:0]      aluShamt;  // Remaining shift positions
   logic [2:0]      funct3;

   assign funct3 = dec.instr.r.funct3;
   assign aluIn1 = rs1Data;

   // rs2 for register ops and branches, immS for stores, immI otherwise
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Data :
                   dec.isStore                   ? dec.immS : dec.immI;

   // ****************************************
   // Adder and comparator
   // ****************************************
   assign aluPlus  = aluIn1 + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;  // One subtract for all compares
   assign isLtu    = aluMinus[xlen];
   assign isLt     = (aluIn1[xlen-1] ^ aluIn2[xlen-1]) ? aluIn1[xlen-1] : aluMinus[xlen];
   assign isEq     = (aluMinus[xlen-1:0] == '0);

   assign aluOut  = aluReg;
   assign aluBusy = |aluShamt;

   // ****************************************
   // Result register and shifter
   // ****************************************
   always_ff @(posedge clk) begin
      if (aluWr) begin
         case (funct3)
            3'b000: aluReg <= (dec.instr.r.funct7[5] & dec.isAluReg) ?
                              aluMinus[xlen-1:0] : aluPlus;   // SUB only for register form
            3'b010: aluReg <= {{(xlen-1){1'b0}}, isLt};       // SLT
            3'b011: aluReg <= {{(xlen-1){1'b0}}, isLtu};      // SLTU
            3'b100: aluReg <= aluIn1 ^ aluIn2;
            3'b110: aluReg <= aluIn1 | aluIn2;
            3'b111: aluReg <= aluIn1 & aluIn2;
            default: begin                                    // SLL, SRL, SRA
               aluReg   <= aluIn1;
               aluShamt <= aluIn2[4:0];
            end
         endcase
      end else if (aluBusy) begin
         aluShamt <= aluShamt - 5'd1;
         // funct3[2] picks right shift, bit 30 picks arithmetic
         aluReg   <= funct3[2] ? {dec.instr.r.funct7[5] & aluReg[xlen-1], aluReg[xlen-1:1]}
                               : {aluReg[xlen-2:0], 1'b0};
      end
   end

   // Six branch conditions
   always_comb begin
      case (funct3)
         3'b000:  predicate = isEq;    // BEQ
         3'b001:  predicate = !isEq;   // BNE
         3'b100:  predicate = isLt;    // BLT
         3'b101:  predicate = !isLt;   // BGE
         3'b110:  predicate = isLtu;   // BLTU
         3'b111:  predicate = !isLtu;  // BGEU
         default: predicate = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
   input  wire                       clk,
   input  wire  [4:0]                rs1,
   input  wire  [4:0]                rs2,
   input  wire  [4:0]                rd,
   input  wire                       writeBack,      // Write strobe
   input  wire  [quarkPkg::xlen-1:0] writeBackData,
   output logic [quarkPkg::xlen-1:0] rs1Data,        // One cycle after rs1
   output logic [quarkPkg::xlen-1:0] rs2Data         // One cycle after rs2
);
   import quarkPkg::*;

   logic [xlen-1:0] regs [0:31];

   // Two read ports and one write port, all on the same edge
   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads as zero
      rs2Data <= (rs2 == 5'd0) ? '0 : regs[rs2];
      if (writeBack && (rd != 5'd0)) begin
         regs[rd] <= writeBackData;
      end
   end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  wire                      clk,
   input  wire [quarkPkg::xlen-1:0] memRdata,   // Fetched word
   input  wire                      instrLoad,  // Capture strobe from the FSM
   decodeBus.producer               dec
);
   import quarkPkg::*;

   // Bits 1..0 are always 11 in RV32I
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         dec.instr <= memRdata[31:2];
      end
   end

   // ****************************************
   // Opcode flags, one cycle behind instr
   // ****************************************
   always_ff @(posedge clk) begin
      dec.isLoad   <= (dec.instr.r.opcode == opLoad);
      dec.isAluImm <= (dec.instr.r.opcode == opAluImm);
      dec.isAuipc  <= (dec.instr.r.opcode == opAuipc);
      dec.isStore  <= (dec.instr.r.opcode == opStore);
      dec.isAluReg <= (dec.instr.r.opcode == opAluReg);
      dec.isLui    <= (dec.instr.r.opcode == opLui);
      dec.isBranch <= (dec.instr.r.opcode == opBranch);
      dec.isJalr   <= (dec.instr.r.opcode == opJalr);
      dec.isJal    <= (dec.instr.r.opcode == opJal);
   end

   // ****************************************
   // Immediates
   // ****************************************
   // Upper view gives U and J
   assign dec.immU = {dec.instr.u.imm20, 12'b0};
   assign dec.immJ = {{12{dec.instr.u.imm20[19]}},
                      dec.instr.u.imm20[7:0],    // Bits 19..12
                      dec.instr.u.imm20[8],      // Bit 20
                      dec.instr.u.imm20[18:9],   // Bits 30..21
                      1'b0};

   // Register view gives I, S and B, sign always in funct7[6]
   assign dec.immI = {{21{dec.instr.r.funct7[6]}}, dec.instr.r.funct7[5:0], dec.instr.r.rs2};
   assign dec.immS = {{21{dec.instr.r.funct7[6]}}, dec.instr.r.funct7[5:0], dec.instr.r.rd};
   assign dec.immB = {{20{dec.instr.r.funct7[6]}},
                      dec.instr.r.rd[0],         // Bit 11 of offset
                      dec.instr.r.funct7[5:0],
                      dec.instr.r.rd[4:1],
                      1'b0};

endmodule

`default_nettype wire

//--- verilog/decodeBus.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeBus;
   import quarkPkg::*;

   instrWord_t instr;  // Latched instruction

   // Opcode flags, one per instruction class
   logic isLoad;
   logic isAluImm;
   logic isAuipc;
   logic isStore;
   logic isAluReg;
   logic isLui;
   logic isBranch;
   logic isJalr;
   logic isJal;

   // Sign-extended immediates
   logic [xlen-1:0] immU;
   logic [xlen-1:0] immI;
   logic [xlen-1:0] immS;
   logic [xlen-1:0] immB;
   logic [xlen-1:0] immJ;

   modport producer (output instr, isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui,
                     isBranch, isJalr, isJal, immU, immI, immS, immB, immJ);

   modport consumer (input instr, isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui,
                     isBranch, isJalr, isJal, immU, immI, immS, immB, immJ);

endinterface

`default_nettype wire

//--- verilog/quarkPkg.sv
`default_nettype none

package quarkPkg;

   // ****************************************
   // Core dimensions
   // ****************************************
   localparam int addrWidth = 24;                    // Bits kept in PC and address register
   localparam int xlen      = 32;                    // Data path width
   localparam logic [addrWidth-1:0] resetAddr = '0;  // First fetch after reset

   // Major opcodes, instruction bits 6..2
   localparam logic [4:0] opLoad   = 5'b00000;  // rd <- mem[rs1+immI]
   localparam logic [4:0] opAluImm = 5'b00100;  // rd <- rs1 op immI
   localparam logic [4:0] opAuipc  = 5'b00101;  // rd <- pc+immU
   localparam logic [4:0] opStore  = 5'b01000;  // mem[rs1+immS] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100;  // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101;  // rd <- immU
   localparam logic [4:0] opBranch = 5'b11000;  // if (rs1 op rs2) pc <- pc+immB
   localparam logic [4:0] opJalr   = 5'b11001;  // rd <- pc+4, pc <- rs1+immI
   localparam logic [4:0] opJal    = 5'b11011;  // rd <- pc+4, pc <- pc+immJ

   // ****************************************
   // One-hot state bit positions
   // ****************************************
   localparam int stFetchInstr   = 0;  // Fetch address out, instruction in flight
   localparam int stWaitInstr    = 1;  // Latch instruction once memory is ready
   localparam int stFetchRegs    = 2;  // Register reads in flight
   localparam int stExecute      = 3;  // Branch point of the FSM
   localparam int stLoad         = 4;  // Load address out, data in flight
   localparam int stWaitAluOrMem = 5;  // Shift or memory still busy
   localparam int stStore        = 6;  // Write mask on the bus
   localparam int numStates      = 7;

   // Instruction bits 31..2, seen as register format or as upper immediate
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [4:0] opcode;
      } r;
      struct packed {
         logic [19:0] imm20;  // Bits 31..12, also carries the J immediate
         logic [4:0]  rd;
         logic [4:0]  opcode;
      } u;
   } instrWord_t;

endpackage

`default_nettype wire
